// ==== flow_deserializer.f ====
+incdir+.
flow_deser_pkg.sv
slice_assembler.sv
packet_flow_ctrl.sv
flow_deserializer.sv
flow_deserializer_sva.sv
tb_flow_deserializer.sv

// ==== Makefile ====
# Verilator build and run for the flow deserializer

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_flow_deserializer
FILELIST  ?= flow_deserializer.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_flow_deserializer.sv ====
// Flow deserializer testbench
`timescale 1ns/100ps
`include "flow_deser_defines.svh"

module tb_flow_deserializer;

  // ----------------------------------------------------------------------
  // Run parameters
  // ----------------------------------------------------------------------

  localparam int HALF            = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int PUSH_W          = `FD_PUSH_WIDTH;
  localparam int POP_W           = `FD_POP_WIDTH;
  localparam int RATIO           = `FD_RATIO;
  localparam int MAX_LEN         = 11;
  localparam int RESET_PKTS      = 2;
  localparam int FULL_PKTS       = 8;
  localparam int EARLY_PKTS      = 12;
  localparam int BP_PKTS         = 40;
  localparam int TOTAL_PKTS      = RESET_PKTS + FULL_PKTS + EARLY_PKTS + BP_PKTS;
  // Generous bound of 20 cycles per push flit for the longest possible run
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * MAX_LEN * 20;

  logic                       clk;
  logic                       arst_n;
  logic                       push_valid;
  logic                       push_ready;
  flow_deser_pkg::push_data_t push_data;
  logic                       push_last;
  flow_deser_pkg::meta_t      push_metadata;
  logic                       pop_valid;
  logic                       pop_ready;
  flow_deser_pkg::pop_data_t  pop_data;
  logic                       pop_last;
  flow_deser_pkg::flit_id_t   pop_dont_care_count;
  flow_deser_pkg::meta_t      pop_metadata;

  // Expected pop flits in delivery order with one entry per group of up to RATIO flits
  logic [31:0] exp_data_q[$];
  logic [31:0] exp_mask_q[$];
  logic [31:0] exp_last_q[$];
  logic [31:0] exp_dcc_q[$];
  logic [31:0] exp_meta_q[$];

  int error_count = 0;
  int check_count = 0;
  int pop_count   = 0;
  int model_count = 0;
  // Chance in percent that the sink is ready and that the source idles
  int ready_pct   = 100;
  int idle_pct    = 0;
  logic [31:0] lcg_state = 32'd71;

  flow_deserializer flow_deserializer_i (
    .clk                 (clk),
    .arst_n              (arst_n),
    .push_valid          (push_valid),
    .push_ready          (push_ready),
    .push_data           (push_data),
    .push_last           (push_last),
    .push_metadata       (push_metadata),
    .pop_valid           (pop_valid),
    .pop_ready           (pop_ready),
    .pop_data            (pop_data),
    .pop_last            (pop_last),
    .pop_dont_care_count (pop_dont_care_count),
    .pop_metadata        (pop_metadata)
  );

  initial begin
    clk = 1'b0;
    forever #(HALF) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Classic 32-bit LCG step
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper state bits are the better distributed ones
  function automatic int rand_range(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'({17'd0, r[30:16]}) % n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
    end
  endtask

  // Drives pop_ready on the falling edge like every other input
  task automatic step_negedge();
    @(negedge clk);
    pop_ready = (rand_range(100) < ready_pct);
  endtask

  // Presents one flit and holds it until the DUT takes it
  // Sampling sits 1 ns before the rising edge where all inputs are settled
  task automatic send_flit(input flow_deser_pkg::push_data_t data, input logic last,
                           input flow_deser_pkg::meta_t meta);
    logic accepted;
    step_negedge();
    while (rand_range(100) < idle_pct) begin
      push_valid = 1'b0;
      step_negedge();
    end
    push_valid    = 1'b1;
    push_data     = data;
    push_last     = last;
    push_metadata = meta;
    accepted      = 1'b0;
    while (!accepted) begin
      #(HALF - 1);
      accepted = push_ready;
      @(posedge clk);
      if (!accepted) begin
        step_negedge();
      end
    end
  endtask

  // Splits a packet into groups and queues the expected pop flit of each
  task automatic send_packet(input int len);
    flow_deser_pkg::push_data_t group_flits [RATIO];
    flow_deser_pkg::meta_t      meta;
    logic [31:0]                word;
    logic [31:0]                mask;
    logic                       last_group;
    int                         sent;
    int                         group_n;
    int                         top;
    sent = 0;
    while (sent < len) begin
      group_n    = (len - sent < RATIO) ? len - sent : RATIO;
      last_group = (sent + group_n == len);
      meta       = flow_deser_pkg::meta_t'(lcg_next() >> 20);
      word       = '0;
      mask       = '0;
      // First flit of the group goes into the top slice and the rest follow downward
      for (int k = 0; k < group_n; k++) begin
        group_flits[k] = flow_deser_pkg::push_data_t'(lcg_next() >> 8);
        top = POP_W - 1 - k * PUSH_W;
        word[top -: PUSH_W] = group_flits[k];
        mask[top -: PUSH_W] = '1;
      end
      exp_data_q.push_back(word);
      exp_mask_q.push_back(mask);
      exp_last_q.push_back(32'(last_group));
      if (last_group) begin
        exp_dcc_q.push_back(32'(RATIO - group_n));
      end else begin
        exp_dcc_q.push_back(32'd0);
      end
      exp_meta_q.push_back(32'(meta));
      model_count++;
      for (int k = 0; k < group_n; k++) begin
        send_flit(group_flits[k], (sent + k == len - 1), meta);
      end
      sent += group_n;
    end
  endtask

  task automatic go_idle();
    step_negedge();
    push_valid = 1'b0;
    push_last  = 1'b0;
    #(HALF - 1);
    @(posedge clk);
  endtask

  // Holds reset, then checks the idle outputs for a few cycles
  task automatic apply_reset();
    step_negedge();
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_last  = 1'b0;
    repeat (RESET_CYCLES) step_negedge();
    arst_n = 1'b1;
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        step_negedge();
      end
      #(HALF - 1);
      check_value("pop_valid", 32'(pop_valid), 32'd0);
      check_value("push_ready", 32'(push_ready), 32'd1);
      @(posedge clk);
    end
  endtask

  task automatic finish_test(input string name, input int err_start, input int pop_start);
    if (exp_data_q.size() != 0) begin
      error_count++;
      $display("ERROR: test %s ended with %0d expected pop flits never delivered",
               name, exp_data_q.size());
    end
    $display("test %s finished: %0d pop flits, %0d errors",
             name, pop_count - pop_start, error_count - err_start);
  endtask

  // ----------------------------------------------------------------------
  // Pop monitor
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] mask;
    forever begin
      @(negedge clk);
      #(HALF - 1);
      if (arst_n && pop_valid && pop_ready) begin
        if (exp_data_q.size() == 0) begin
          error_count++;
          $display("ERROR: pop flit delivered at %0t with nothing expected", $time);
        end else begin
          mask = exp_mask_q.pop_front();
          check_value("pop_data", pop_data & mask, exp_data_q.pop_front() & mask);
          check_value("pop_last", 32'(pop_last), exp_last_q.pop_front());
          check_value("pop_dont_care_count", 32'(pop_dont_care_count),
                      exp_dcc_q.pop_front());
          check_value("pop_metadata", 32'(pop_metadata), exp_meta_q.pop_front());
        end
        pop_count++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles before all packets were delivered",
             WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int len;
    int err_start;
    int pop_start;
    arst_n        = 1'b0;
    push_valid    = 1'b0;
    push_data     = '0;
    push_last     = 1'b0;
    push_metadata = '0;
    pop_ready     = 1'b0;

    err_start = error_count;
    pop_start = pop_count;
    apply_reset();
    send_packet(3);
    go_idle();
    finish_test("reset", err_start, pop_start);

    // Lengths are whole multiples of the ratio so every pop flit is full
    err_start = error_count;
    pop_start = pop_count;
    for (int p = 0; p < FULL_PKTS; p++) begin
      send_packet(RATIO * (1 + rand_range(2)));
    end
    go_idle();
    finish_test("full_packets", err_start, pop_start);

    // Lengths that are never a multiple of the ratio end in a partial group
    err_start = error_count;
    pop_start = pop_count;
    for (int p = 0; p < EARLY_PKTS; p++) begin
      len = 1 + rand_range(MAX_LEN);
      if (len % RATIO == 0) begin
        len = len - 1;
      end
      send_packet(len);
    end
    go_idle();
    finish_test("early_close", err_start, pop_start);

    err_start = error_count;
    pop_start = pop_count;
    ready_pct = 50;
    idle_pct  = 20;
    for (int p = 0; p < BP_PKTS; p++) begin
      send_packet(1 + rand_range(MAX_LEN));
    end
    go_idle();
    ready_pct = 100;
    idle_pct  = 0;
    finish_test("back_pressure", err_start, pop_start);

    // Two staged flits leave the slice index away from zero before the source idles
    // After the second reset the next packet must again start at the top slice
    err_start = error_count;
    pop_start = pop_count;
    for (int k = 0; k < 2; k++) begin
      send_flit(flow_deser_pkg::push_data_t'(lcg_next() >> 8), 1'b0,
                flow_deser_pkg::meta_t'(0));
    end
    go_idle();
    apply_reset();
    send_packet(3);
    go_idle();
    finish_test("mid_run_reset", err_start, pop_start);

    check_value("pop_count", 32'(pop_count), 32'(model_count));
    $display("checks %0d, errors %0d, pop flits %0d, expected pop flits %0d",
             check_count, error_count, pop_count, model_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== flow_deserializer_sva.sv ====
// Flow deserializer port assertions
`timescale 1ns/100ps

module flow_deserializer_sva (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       push_valid,
  input logic                       push_ready,
  input flow_deser_pkg::push_data_t push_data,
  input logic                       push_last,
  input flow_deser_pkg::meta_t      push_metadata,
  input logic                       pop_valid,
  input logic                       pop_ready,
  input flow_deser_pkg::pop_data_t  pop_data,
  input logic                       pop_last,
  input flow_deser_pkg::flit_id_t   pop_dont_care_count,
  input flow_deser_pkg::meta_t      pop_metadata
);

  // ----------------------------------------------------------------------
  // Push side
  // ----------------------------------------------------------------------

  // A stalled push flit must be held as it is until accepted
  push_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    (push_valid && !push_ready) |=> (push_valid && $stable(push_data) &&
      $stable(push_last) && $stable(push_metadata)))
    else $error("push inputs changed while stalled");

  // ----------------------------------------------------------------------
  // Pop side
  // ----------------------------------------------------------------------

  // Zero latency means a pop flit can only exist next to its closing push flit
  pop_needs_push_a : assert property (@(posedge clk) disable iff (!arst_n)
    pop_valid |-> push_valid)
    else $error("pop_valid without push_valid");

  // Only the final pop flit of a packet may have a tail
  dcc_zero_a : assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_last) |-> (pop_dont_care_count == '0))
    else $error("nonzero don't-care count on a pop flit without pop_last");

  pop_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data) && $stable(pop_last) &&
      $stable(pop_dont_care_count) && $stable(pop_metadata)))
    else $error("pop outputs changed while stalled");

endmodule

bind flow_deserializer flow_deserializer_sva flow_deserializer_sva_i (
  .clk                 (clk),
  .arst_n              (arst_n),
  .push_valid          (push_valid),
  .push_ready          (push_ready),
  .push_data           (push_data),
  .push_last           (push_last),
  .push_metadata       (push_metadata),
  .pop_valid           (pop_valid),
  .pop_ready           (pop_ready),
  .pop_data            (pop_data),
  .pop_last            (pop_last),
  .pop_dont_care_count (pop_dont_care_count),
  .pop_metadata        (pop_metadata)
);

// ==== flow_deserializer.sv ====
// Stream flit deserializer top
`timescale 1ns/100ps

module flow_deserializer (
  input  logic                      clk,
  input  logic                      arst_n,

  // ----------------------------------------------------------------------
  // Push side, narrow flits
  // ----------------------------------------------------------------------

  input  logic                      push_valid,
  output logic                      push_ready,
  input  flow_deser_pkg::push_data_t push_data,
  // Marks the final flit of a packet and may close a pop flit early
  input  logic                      push_last,
  // Sampled on the flit that closes each pop flit
  input  flow_deser_pkg::meta_t      push_metadata,

  // ----------------------------------------------------------------------
  // Pop side, wide flits
  // ----------------------------------------------------------------------

  output logic                      pop_valid,
  input  logic                      pop_ready,
  // First push flit of the group sits in the top slice
  output flow_deser_pkg::pop_data_t  pop_data,
  // High on the final pop flit of a packet
  output logic                      pop_last,
  // Number of unfilled slices at the tail, valid with pop_last
  output flow_deser_pkg::flit_id_t   pop_dont_care_count,
  output flow_deser_pkg::meta_t      pop_metadata
);

  // Slice currently being filled
  flow_deser_pkg::flit_id_t flit_id;

  // Write strobe for the staging registers
  logic stage_load;

  // ----------------------------------------------------------------------
  // Handshake and sideband control
  // ----------------------------------------------------------------------

  packet_flow_ctrl packet_flow_ctrl_i (
    .clk                 (clk),
    .arst_n              (arst_n),
    .push_valid          (push_valid),
    .push_last           (push_last),
    .push_metadata       (push_metadata),
    .push_ready          (push_ready),
    .pop_ready           (pop_ready),
    .pop_valid           (pop_valid),
    .pop_last            (pop_last),
    .pop_dont_care_count (pop_dont_care_count),
    .pop_metadata        (pop_metadata),
    .flit_id             (flit_id),
    .stage_load          (stage_load)
  );

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  // Builds the wide flit from staged slices and the live push flit
  slice_assembler slice_assembler_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .flit_id    (flit_id),
    .stage_load (stage_load),
    .push_data  (push_data),
    .pop_data   (pop_data)
  );

endmodule

// ==== packet_flow_ctrl.sv ====
// Packet flow controller
`timescale 1ns/100ps
`include "flow_deser_defines.svh"

module packet_flow_ctrl (
  input  logic                    clk,
  input  logic                    arst_n,
  // Push side handshake and sideband
  input  logic                    push_valid,
  input  logic                    push_last,
  input  flow_deser_pkg::meta_t    push_metadata,
  output logic                    push_ready,
  // Pop side handshake and sideband
  input  logic                    pop_ready,
  output logic                    pop_valid,
  output logic                    pop_last,
  output flow_deser_pkg::flit_id_t pop_dont_care_count,
  output flow_deser_pkg::meta_t    pop_metadata,
  // Control towards the slice assembler
  output flow_deser_pkg::flit_id_t flit_id,
  output logic                    stage_load
);

  // Index of the final slice in a pop flit
  localparam flow_deser_pkg::flit_id_t LAST_ID = flow_deser_pkg::flit_id_t'(`FD_RATIO - 1);

  // ----------------------------------------------------------------------
  // Closing decision
  // ----------------------------------------------------------------------

  // Current slice index within the pop flit under construction
  flow_deser_pkg::flit_id_t flit_id_q;

  // High when the present push flit completes a pop flit
  logic closing;

  // Handshake events on both sides
  logic push_acc;
  logic pop_acc;

  // A pop flit closes when it is full or when the packet ends early
  assign closing = (flit_id_q == LAST_ID) || push_last;

  // ----------------------------------------------------------------------
  // Ready and valid
  // ----------------------------------------------------------------------

  // The closing push flit and its pop flit move together on one edge
  // so the pop flit appears in the same cycle with no added latency
  assign pop_valid = push_valid && closing;

  // Earlier flits only go into staging and are never blocked
  // A closing flit has to wait for the sink
  assign push_ready = closing ? pop_ready : 1'b1;

  assign push_acc = push_valid && push_ready;
  assign pop_acc  = pop_valid && pop_ready;

  // Staging write for every flit that does not close the pop flit
  assign stage_load = push_acc && !closing;

  // ----------------------------------------------------------------------
  // Flit index counter
  // ----------------------------------------------------------------------

  // Restarts at slice 0 after each delivered pop flit
  // Steps to the next slice after each staged push flit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_id_q <= '0;
    end else if (pop_acc) begin
      flit_id_q <= '0;
    end else if (stage_load) begin
      flit_id_q <= flit_id_q + flow_deser_pkg::flit_id_t'(1);
    end
  end

  assign flit_id = flit_id_q;

  // ----------------------------------------------------------------------
  // Pop sideband
  // ----------------------------------------------------------------------

  // The packet end and metadata are taken from the closing push flit
  assign pop_last     = push_last;
  assign pop_metadata = push_metadata;

  // On an early close the slices after flit_id are unfilled
  // A full pop flit has no don't-care tail, so the count stays 0
  always_comb begin
    if (pop_last) begin
      pop_dont_care_count = LAST_ID - flit_id_q;
    end else begin
      pop_dont_care_count = '0;
    end
  end

endmodule

// ==== slice_assembler.sv ====
// Wide flit slice assembler
`timescale 1ns/100ps
`include "flow_deser_defines.svh"

module slice_assembler (
  input  logic                      clk,
  input  logic                      arst_n,
  // Slice that the current push flit belongs to
  input  flow_deser_pkg::flit_id_t   flit_id,
  // High on the acceptance of a push flit that does not close the pop flit
  input  logic                      stage_load,
  input  flow_deser_pkg::push_data_t push_data,
  // Assembled wide flit, most significant slice first
  output flow_deser_pkg::pop_data_t  pop_data
);

  // Slices per pop flit and the width of each slice
  localparam int RATIO   = `FD_RATIO;
  localparam int PUSH_W  = `FD_PUSH_WIDTH;

  // ----------------------------------------------------------------------
  // Staging registers
  // ----------------------------------------------------------------------

  // One register per slice except the final slice
  flow_deser_pkg::slice_array_t stage_q;

  // Decoded write strobe for each staging register
  logic [RATIO-2:0] stage_we;

  for (genvar i = 0; i < RATIO - 1; i++) begin : gen_stage
    // Only the register that flit_id points at takes the flit
    assign stage_we[i] = stage_load && (flit_id == flow_deser_pkg::flit_id_t'(i));

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        stage_q[i] <= '0;
      end else if (stage_we[i]) begin
        stage_q[i] <= push_data;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Pop flit formation
  // ----------------------------------------------------------------------

  // Slice i sits at bit offset (RATIO-1-i)*PUSH_W, so slice 0 is on top
  // A slice equal to flit_id is being delivered right now and bypasses its register
  // Slices below flit_id were filled on earlier cycles and come from staging
  // Slices above flit_id are stale and only matter as don't-care contents
  for (genvar i = 0; i < RATIO - 1; i++) begin : gen_slice_mux
    localparam int LSB = (RATIO - 1 - i) * PUSH_W;

    // Select the live push flit for the slice that is closing the group
    logic bypass;

    assign bypass = (flit_id == flow_deser_pkg::flit_id_t'(i));

    assign pop_data[LSB +: PUSH_W] = bypass ? push_data : stage_q[i];
  end

  // The final slice has no staging register
  // When the group reaches it the push flit itself fills the bottom bits
  assign pop_data[PUSH_W-1:0] = push_data;

endmodule

// ==== flow_deser_pkg.sv ====
// Flow deserializer shared types
`include "flow_deser_defines.svh"

package flow_deser_pkg;

  // ----------------------------------------------------------------------
  // Payload types
  // ----------------------------------------------------------------------

  // One narrow flit as it arrives on the push side
  typedef logic [`FD_PUSH_WIDTH-1:0] push_data_t;

  // One wide flit as it leaves on the pop side
  // The first push flit of a group lands in the top slice
  typedef logic [`FD_POP_WIDTH-1:0] pop_data_t;

  // Packet metadata, held constant by the sender within one pop flit
  typedef logic [`FD_META_WIDTH-1:0] meta_t;

  // ----------------------------------------------------------------------
  // Control types
  // ----------------------------------------------------------------------

  // Index of the slice that the current push flit fills
  // Slice 0 is the most significant slice of the pop flit
  typedef logic [`FD_ID_WIDTH-1:0] flit_id_t;

  // Staging storage for every slice except the final one
  // The final slice never needs a register because it always closes the pop flit
  // Entry 0 holds the first push flit of the group
  typedef logic [`FD_RATIO-2:0][`FD_PUSH_WIDTH-1:0] slice_array_t;

endpackage

// ==== flow_deser_defines.svh ====
// Flow deserializer width macros
`ifndef FLOW_DESER_DEFINES_SVH
`define FLOW_DESER_DEFINES_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------

// Width of one narrow flit on the push side
`define FD_PUSH_WIDTH 8

// Width of one wide flit on the pop side
// It must be a whole multiple of the push width
`define FD_POP_WIDTH 32

// Width of the sideband metadata that travels next to each packet
`define FD_META_WIDTH 3

// ----------------------------------------------------------------------
// Derived values
// ----------------------------------------------------------------------

// Number of push flits that make up one full pop flit
`define FD_RATIO (`FD_POP_WIDTH / `FD_PUSH_WIDTH)

// Bits needed to name one slice of a pop flit
// Also wide enough for the don't-care count, which is at most ratio-1
`define FD_ID_WIDTH $clog2(`FD_RATIO)

`endif
